//--- tcp_config.svh
`ifndef TCP_CONFIG_SVH
`define TCP_CONFIG_SVH

// retransmission
`define TCP_RETX_CYCLES 64
`define TCP_MAX_RETRIES 3

// fixed advertised window
`define TCP_RX_WINDOW 16'h1000

// register offsets
`define TCP_REG_CTRL   8'h00
`define TCP_REG_PORTS  8'h04
`define TCP_REG_ISN    8'h08
`define TCP_REG_STATUS 8'h0C

`endif

//--- tcp_pkg.sv
package tcp_pkg;

    typedef logic [31:0] tcp_seq_t;
    typedef logic [15:0] tcp_port_t;
    typedef logic [7:0]  tcp_flags_t;
    typedef logic [15:0] tcp_win_t;

    // flag bits as they sit in the header
    localparam tcp_flags_t TCP_FLAG_FIN = 8'h01;
    localparam tcp_flags_t TCP_FLAG_SYN = 8'h02;
    localparam tcp_flags_t TCP_FLAG_RST = 8'h04;
    localparam tcp_flags_t TCP_FLAG_ACK = 8'h10;

    typedef enum logic [3:0] {
        CLOSED,
        SYN_SENT,
        ESTABLISHED,
        FIN_WAIT,
        ERROR
    } tcp_state_e;

    typedef struct packed {
        tcp_port_t  src_port;
        tcp_port_t  dst_port;
        tcp_seq_t   seq;
        tcp_seq_t   ack;
        tcp_flags_t flags;
        tcp_win_t   window;
    } tcp_hdr_t;

    typedef enum logic [1:0] {SEND_SYN, SEND_ACK, SEND_FIN, RESEND} tcp_cmd_e;

    typedef struct packed {
        tcp_cmd_e kind;
        tcp_seq_t ack_num;
    } tcp_cmd_t;

    typedef enum logic [1:0] {MSG_SYNACK, MSG_ACK, MSG_FIN, MSG_RST} tcp_msg_e;

    // rcv_nxt is the peer seq + 1
    typedef struct packed {
        tcp_msg_e kind;
        logic     ack_ok;
        tcp_seq_t rcv_nxt;
    } tcp_rx_msg_t;

    typedef struct packed {
        logic      enable;
        tcp_port_t src_port;
        tcp_port_t dst_port;
        tcp_seq_t  isn;
    } tcp_cfg_t;

    typedef struct packed {
        tcp_state_e state;
        logic       error;
    } tcp_stat_t;

endpackage

//--- tcp_stream_regs.sv
`timescale 1ns/1ns
`include "tcp_config.svh"

module tcp_stream_regs (
    input  logic               i_clk,
    input  logic               i_rst_n,

    input  logic [7:0]         i_awaddr,
    input  logic               i_awvalid,
    output logic               o_awready,
    input  logic [31:0]        i_wdata,
    input  logic               i_wvalid,
    output logic               o_wready,
    output logic [1:0]         o_bresp,
    output logic               o_bvalid,
    input  logic               i_bready,
    input  logic [7:0]         i_araddr,
    input  logic               i_arvalid,
    output logic               o_arready,
    output logic [31:0]        o_rdata,
    output logic [1:0]         o_rresp,
    output logic               o_rvalid,
    input  logic               i_rready,

    output tcp_pkg::tcp_cfg_t  o_cfg,
    output logic               o_open,
    output logic               o_close,
    input  tcp_pkg::tcp_stat_t i_stat
);
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        wr_fire;
    logic        wr_ok;
    logic        rd_ok;
    logic [31:0] rd_word;
    logic        open_req;
    logic        close_req;

    // AW and W are taken together, one transaction at a time
    assign o_awready = i_awvalid & i_wvalid & ~o_bvalid & ~o_rvalid;
    assign o_wready  = o_awready;
    assign wr_fire   = o_awready;
    assign o_arready = i_arvalid & ~o_rvalid & ~o_bvalid & ~(i_awvalid & i_wvalid);

    assign wr_ok = i_awaddr inside {`TCP_REG_CTRL, `TCP_REG_PORTS, `TCP_REG_ISN,
                                    `TCP_REG_STATUS};

    always_comb begin
        rd_ok = 1'b1;
        case (i_araddr)
            `TCP_REG_CTRL:   rd_word = {31'b0, o_cfg.enable};
            `TCP_REG_PORTS:  rd_word = {o_cfg.dst_port, o_cfg.src_port};
            `TCP_REG_ISN:    rd_word = o_cfg.isn;
            `TCP_REG_STATUS: rd_word = {23'b0, i_stat.error, 4'b0, i_stat.state};
            default: begin
                rd_word = '0;
                rd_ok   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_bvalid  <= 1'b0;
            o_rvalid  <= 1'b0;
            o_cfg     <= '0;
            open_req  <= 1'b0;
            close_req <= 1'b0;
            o_open    <= 1'b0;
            o_close   <= 1'b0;
        end else begin
            // pulses leave one cycle after the B response
            o_open    <= open_req;
            o_close   <= close_req;
            open_req  <= 1'b0;
            close_req <= 1'b0;
            if (o_bvalid && i_bready) begin
                o_bvalid <= 1'b0;
            end
            if (o_rvalid && i_rready) begin
                o_rvalid <= 1'b0;
            end
            if (wr_fire) begin
                o_bvalid <= 1'b1;
                case (i_awaddr)
                    `TCP_REG_CTRL: begin
                        o_cfg.enable <= i_wdata[0];
                        open_req     <= i_wdata[1];
                        close_req    <= i_wdata[2];
                    end
                    `TCP_REG_PORTS: begin
                        o_cfg.src_port <= i_wdata[15:0];
                        o_cfg.dst_port <= i_wdata[31:16];
                    end
                    `TCP_REG_ISN: o_cfg.isn <= i_wdata;
                    default: ;
                endcase
            end
            if (o_arready) begin
                o_rvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_fire) begin
            o_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (o_arready) begin
            o_rdata <= rd_word;
            o_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

//--- tcp_state_manager.sv
`timescale 1ns/1ns

module tcp_state_manager (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_enable,
    input  logic                 i_open,
    input  logic                 i_close,

    output tcp_pkg::tcp_cmd_t    o_cmd,
    output logic                 o_cmd_valid,
    input  logic                 i_cmd_ready,

    input  tcp_pkg::tcp_rx_msg_t i_msg,
    input  logic                 i_msg_valid,
    output logic                 o_msg_ready,

    output logic                 o_timer_start,
    output logic                 o_timer_stop,
    output logic                 o_retry_clr,
    input  logic                 i_timeout,
    input  logic                 i_retries_exhausted,

    output tcp_pkg::tcp_stat_t   o_stat
);
    import tcp_pkg::*;

    tcp_state_e state_q;
    tcp_state_e state_d;
    tcp_cmd_t   cmd_d;
    logic       issue;
    logic       error_q;
    logic       arm_q;
    logic       msg_fire;
    logic       reply_ok;

    // messages wait while a command is still pending
    assign o_msg_ready = ~o_cmd_valid;
    assign msg_fire    = i_msg_valid & o_msg_ready;
    assign reply_ok    = msg_fire & i_msg.ack_ok &
                         ((state_q == SYN_SENT) ? (i_msg.kind == MSG_SYNACK)
                                                : (i_msg.kind == MSG_ACK));

    // timer runs once the SYN or FIN header has left tx_ctrl
    assign o_timer_start = arm_q & i_cmd_ready;
    assign o_stat        = '{state: state_q, error: error_q};

    always_comb begin
        state_d      = state_q;
        cmd_d        = o_cmd;
        issue        = 1'b0;
        o_timer_stop = 1'b0;
        o_retry_clr  = 1'b0;
        if (i_enable) begin
            if (msg_fire && i_msg.kind == MSG_RST) begin
                state_d      = ERROR;
                o_timer_stop = 1'b1;
            end else begin
                case (state_q)
                    CLOSED, ERROR: begin
                        if (i_open && !o_cmd_valid) begin
                            issue       = 1'b1;
                            cmd_d.kind  = SEND_SYN;
                            o_retry_clr = 1'b1;
                            state_d     = SYN_SENT;
                        end
                    end
                    ESTABLISHED: begin
                        if (i_close && !o_cmd_valid) begin
                            issue       = 1'b1;
                            cmd_d.kind  = SEND_FIN;
                            o_retry_clr = 1'b1;
                            state_d     = FIN_WAIT;
                        end
                    end
                    SYN_SENT, FIN_WAIT: begin
                        if (reply_ok) begin
                            o_timer_stop = 1'b1;
                            if (state_q == SYN_SENT) begin
                                issue         = 1'b1;
                                cmd_d.kind    = SEND_ACK;
                                cmd_d.ack_num = i_msg.rcv_nxt;
                                state_d       = ESTABLISHED;
                            end else begin
                                state_d = CLOSED;
                            end
                        end else if (i_timeout) begin
                            if (i_retries_exhausted) begin
                                state_d      = ERROR;
                                o_timer_stop = 1'b1;
                            end else if (!o_cmd_valid) begin
                                issue      = 1'b1;
                                cmd_d.kind = RESEND;
                            end
                        end
                    end
                    default: state_d = CLOSED;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q     <= CLOSED;
            error_q     <= 1'b0;
            o_cmd_valid <= 1'b0;
            arm_q       <= 1'b0;
        end else begin
            state_q <= state_d;
            // sticky until an open leaves ERROR
            if (state_d == ERROR) begin
                error_q <= 1'b1;
            end else if (state_q == ERROR) begin
                error_q <= 1'b0;
            end
            if (issue) begin
                o_cmd_valid <= 1'b1;
            end else if (o_cmd_valid && i_cmd_ready) begin
                o_cmd_valid <= 1'b0;
            end
            if (o_timer_stop || o_timer_start) begin
                arm_q <= 1'b0;
            end else if (o_cmd_valid && i_cmd_ready && o_cmd.kind != SEND_ACK) begin
                arm_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            o_cmd <= cmd_d;
        end
    end

endmodule

//--- tcp_retx_timer.sv
`timescale 1ns/1ns
`include "tcp_config.svh"

module tcp_retx_timer (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_stop,
    input  logic i_retry_clr,
    output logic o_timeout,
    output logic o_retries_exhausted
);
    localparam int CNT_W = $clog2(`TCP_RETX_CYCLES);
    localparam int RTY_W = $clog2(`TCP_MAX_RETRIES + 1);
    localparam logic [CNT_W-1:0] LOAD = CNT_W'(`TCP_RETX_CYCLES - 1);

    logic             active;
    logic [CNT_W-1:0] cnt;
    logic [RTY_W-1:0] retries;

    assign o_retries_exhausted = (retries == RTY_W'(`TCP_MAX_RETRIES));

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            active    <= 1'b0;
            cnt       <= '0;
            retries   <= '0;
            o_timeout <= 1'b0;
        end else begin
            o_timeout <= 1'b0;
            if (i_retry_clr) begin
                retries <= '0;
            end
            if (i_start) begin
                active <= 1'b1;
                cnt    <= LOAD;
            end else if (i_stop) begin
                active <= 1'b0;
            end else if (active) begin
                if (cnt == '0) begin
                    // fire and count again
                    o_timeout <= 1'b1;
                    cnt       <= LOAD;
                    if (!o_retries_exhausted) begin
                        retries <= retries + 1'b1;
                    end
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

endmodule

//--- tcp_tx_ctrl.sv
`timescale 1ns/1ns
`include "tcp_config.svh"

module tcp_tx_ctrl (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  tcp_pkg::tcp_cfg_t i_cfg,
    input  tcp_pkg::tcp_cmd_t i_cmd,
    input  logic              i_cmd_valid,
    output logic              o_cmd_ready,
    output tcp_pkg::tcp_seq_t o_snd_nxt,
    output tcp_pkg::tcp_hdr_t o_tx_hdr,
    output logic              o_tx_hdr_valid,
    input  logic              i_tx_hdr_ready
);
    import tcp_pkg::*;

    logic cmd_fire;

    // one header in flight at a time
    assign o_cmd_ready = ~o_tx_hdr_valid;
    assign cmd_fire    = i_cmd_valid & o_cmd_ready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_tx_hdr_valid <= 1'b0;
            o_snd_nxt      <= '0;
        end else if (cmd_fire) begin
            o_tx_hdr_valid <= 1'b1;
            if (i_cmd.kind == SEND_SYN) begin
                o_snd_nxt <= i_cfg.isn + 1'b1;
            end else if (i_cmd.kind == SEND_FIN) begin
                o_snd_nxt <= o_snd_nxt + 1'b1;
            end
        end else if (o_tx_hdr_valid && i_tx_hdr_ready) begin
            o_tx_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (cmd_fire) begin
            case (i_cmd.kind)
                SEND_SYN: begin
                    o_tx_hdr.seq   <= i_cfg.isn;
                    o_tx_hdr.ack   <= '0;
                    o_tx_hdr.flags <= TCP_FLAG_SYN;
                end
                SEND_ACK: begin
                    o_tx_hdr.seq   <= o_snd_nxt;
                    o_tx_hdr.ack   <= i_cmd.ack_num;
                    o_tx_hdr.flags <= TCP_FLAG_ACK;
                end
                // ack field keeps the value from the last ACK
                SEND_FIN: begin
                    o_tx_hdr.seq   <= o_snd_nxt;
                    o_tx_hdr.flags <= TCP_FLAG_FIN | TCP_FLAG_ACK;
                end
                default: ;
            endcase
            if (i_cmd.kind != RESEND) begin
                o_tx_hdr.src_port <= i_cfg.src_port;
                o_tx_hdr.dst_port <= i_cfg.dst_port;
                o_tx_hdr.window   <= `TCP_RX_WINDOW;
            end
        end
    end

endmodule

//--- tcp_rx_ctrl.sv
`timescale 1ns/1ns

module tcp_rx_ctrl (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  tcp_pkg::tcp_cfg_t    i_cfg,
    input  tcp_pkg::tcp_seq_t    i_snd_nxt,
    input  tcp_pkg::tcp_hdr_t    i_rx_hdr,
    input  logic                 i_rx_hdr_valid,
    output logic                 o_rx_hdr_ready,
    output tcp_pkg::tcp_rx_msg_t o_msg,
    output logic                 o_msg_valid,
    input  logic                 i_msg_ready
);
    import tcp_pkg::*;

    tcp_msg_e kind;
    logic     known;
    logic     port_ok;
    logic     take;

    assign o_rx_hdr_ready = ~o_msg_valid;
    assign port_ok = (i_rx_hdr.dst_port == i_cfg.src_port) &&
                     (i_rx_hdr.src_port == i_cfg.dst_port);
    assign take    = i_rx_hdr_valid & o_rx_hdr_ready & port_ok & known;

    // flag priority RST, SYN+ACK, FIN, ACK
    always_comb begin
        known = 1'b1;
        kind  = MSG_ACK;
        if (|(i_rx_hdr.flags & TCP_FLAG_RST)) begin
            kind = MSG_RST;
        end else if (|(i_rx_hdr.flags & TCP_FLAG_SYN) && |(i_rx_hdr.flags & TCP_FLAG_ACK)) begin
            kind = MSG_SYNACK;
        end else if (|(i_rx_hdr.flags & TCP_FLAG_FIN)) begin
            kind = MSG_FIN;
        end else if (!(|(i_rx_hdr.flags & TCP_FLAG_ACK))) begin
            known = 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_msg_valid <= 1'b0;
        end else if (take) begin
            o_msg_valid <= 1'b1;
        end else if (o_msg_valid && i_msg_ready) begin
            o_msg_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            o_msg.kind    <= kind;
            o_msg.ack_ok  <= (i_rx_hdr.ack == i_snd_nxt);
            o_msg.rcv_nxt <= i_rx_hdr.seq + 1'b1;
        end
    end

endmodule

//--- tcp_stream.sv
`timescale 1ns/1ns

module tcp_stream (
    input  logic              i_clk,
    input  logic              i_rst_n,

    input  logic [7:0]        i_awaddr,
    input  logic              i_awvalid,
    output logic              o_awready,
    input  logic [31:0]       i_wdata,
    input  logic              i_wvalid,
    output logic              o_wready,
    output logic [1:0]        o_bresp,
    output logic              o_bvalid,
    input  logic              i_bready,
    input  logic [7:0]        i_araddr,
    input  logic              i_arvalid,
    output logic              o_arready,
    output logic [31:0]       o_rdata,
    output logic [1:0]        o_rresp,
    output logic              o_rvalid,
    input  logic              i_rready,

    output tcp_pkg::tcp_hdr_t o_tx_hdr,
    output logic              o_tx_hdr_valid,
    input  logic              i_tx_hdr_ready,

    input  tcp_pkg::tcp_hdr_t i_rx_hdr,
    input  logic              i_rx_hdr_valid,
    output logic              o_rx_hdr_ready
);
    import tcp_pkg::*;

    tcp_cfg_t    cfg;
    tcp_stat_t   stat;
    logic        open_pulse;
    logic        close_pulse;

    tcp_cmd_t    cmd;
    logic        cmd_valid;
    logic        cmd_ready;

    tcp_rx_msg_t msg;
    logic        msg_valid;
    logic        msg_ready;

    logic        timer_start;
    logic        timer_stop;
    logic        retry_clr;
    logic        timeout;
    logic        retries_exhausted;
    tcp_seq_t    snd_nxt;

    tcp_stream_regs u_tcp_stream_regs (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_awaddr  (i_awaddr),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_wdata   (i_wdata),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .o_bresp   (o_bresp),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .i_araddr  (i_araddr),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_cfg     (cfg),
        .o_open    (open_pulse),
        .o_close   (close_pulse),
        .i_stat    (stat)
    );

    tcp_state_manager u_tcp_state_manager (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_enable            (cfg.enable),
        .i_open              (open_pulse),
        .i_close             (close_pulse),
        .o_cmd               (cmd),
        .o_cmd_valid         (cmd_valid),
        .i_cmd_ready         (cmd_ready),
        .i_msg               (msg),
        .i_msg_valid         (msg_valid),
        .o_msg_ready         (msg_ready),
        .o_timer_start       (timer_start),
        .o_timer_stop        (timer_stop),
        .o_retry_clr         (retry_clr),
        .i_timeout           (timeout),
        .i_retries_exhausted (retries_exhausted),
        .o_stat              (stat)
    );

    tcp_retx_timer u_tcp_retx_timer (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_start             (timer_start),
        .i_stop              (timer_stop),
        .i_retry_clr         (retry_clr),
        .o_timeout           (timeout),
        .o_retries_exhausted (retries_exhausted)
    );

    tcp_tx_ctrl u_tcp_tx_ctrl (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_cfg          (cfg),
        .i_cmd          (cmd),
        .i_cmd_valid    (cmd_valid),
        .o_cmd_ready    (cmd_ready),
        .o_snd_nxt      (snd_nxt),
        .o_tx_hdr       (o_tx_hdr),
        .o_tx_hdr_valid (o_tx_hdr_valid),
        .i_tx_hdr_ready (i_tx_hdr_ready)
    );

    tcp_rx_ctrl u_tcp_rx_ctrl (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_cfg          (cfg),
        .i_snd_nxt      (snd_nxt),
        .i_rx_hdr       (i_rx_hdr),
        .i_rx_hdr_valid (i_rx_hdr_valid),
        .o_rx_hdr_ready (o_rx_hdr_ready),
        .o_msg          (msg),
        .o_msg_valid    (msg_valid),
        .i_msg_ready    (msg_ready)
    );

endmodule

//--- tcp_stream_sva.sv
`timescale 1ns/1ns
`include "tcp_config.svh"

module tcp_stream_sva (
    input logic              i_clk,
    input logic              i_rst_n,
    input tcp_pkg::tcp_hdr_t i_tx_hdr,
    input logic              i_tx_hdr_valid,
    input logic              i_tx_hdr_ready,
    input logic              i_bvalid,
    input logic [7:0]        i_araddr,
    input logic              i_arvalid,
    input logic              i_arready,
    input logic [31:0]       i_rdata,
    input logic              i_rvalid
);
    import tcp_pkg::*;

    int         fail_count = 0;
    logic [7:0] rd_addr;

    // address of the read being answered
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            rd_addr <= '0;
        end else if (i_arvalid && i_arready) begin
            rd_addr <= i_araddr;
        end
    end

    // stalled header must not move
    a_tx_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_tx_hdr_valid && !i_tx_hdr_ready |=> i_tx_hdr_valid && $stable(i_tx_hdr))
        else begin
            fail_count = fail_count + 1;
            $error("tx header changed or dropped while stalled");
        end

    a_resp_reset: assert property (@(posedge i_clk) !i_rst_n |=> !i_bvalid && !i_rvalid)
        else begin
            fail_count = fail_count + 1;
            $error("bus response valid right after reset");
        end

    a_state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rvalid && rd_addr == `TCP_REG_STATUS) |->
            (i_rdata[3:0] inside {CLOSED, SYN_SENT, ESTABLISHED, FIN_WAIT, ERROR}) &&
            (i_rdata[7:4] == '0) && (i_rdata[31:9] == '0))
        else begin
            fail_count = fail_count + 1;
            $error("status read holds an undefined state");
        end

endmodule

bind tcp_stream tcp_stream_sva u_sva (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_tx_hdr       (o_tx_hdr),
    .i_tx_hdr_valid (o_tx_hdr_valid),
    .i_tx_hdr_ready (i_tx_hdr_ready),
    .i_bvalid       (o_bvalid),
    .i_araddr       (i_araddr),
    .i_arvalid      (i_arvalid),
    .i_arready      (o_arready),
    .i_rdata        (o_rdata),
    .i_rvalid       (o_rvalid)
);

//--- tb_tcp_stream.sv
`timescale 1ns/1ns
`include "tcp_config.svh"

module tb_tcp_stream;
    import tcp_pkg::*;

    localparam int STEP_MAX   = 64;
    localparam int STEP_WORDS = 8;
    localparam int BUS_WAIT   = 50;
    // long enough for one retransmission under back-pressure
    localparam int TX_WAIT    = 4 * `TCP_RETX_CYCLES;
    localparam int unsigned SEED = 95;

    localparam logic [31:0] OP_END   = 32'h0;
    localparam logic [31:0] OP_WRITE = 32'h1;
    localparam logic [31:0] OP_READ  = 32'h2;
    localparam logic [31:0] OP_TX    = 32'h3;
    localparam logic [31:0] OP_RX    = 32'h4;
    localparam logic [31:0] OP_IDLE  = 32'h5;

    logic        clk;
    logic        rst_n;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    tcp_hdr_t    tx_hdr;
    logic        tx_valid;
    logic        tx_ready;
    tcp_hdr_t    rx_hdr;
    logic        rx_valid;
    logic        rx_ready;

    logic [31:0] steps [0:STEP_MAX*STEP_WORDS-1];

    tcp_stream uut (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_awaddr       (awaddr),
        .i_awvalid      (awvalid),
        .o_awready      (awready),
        .i_wdata        (wdata),
        .i_wvalid       (wvalid),
        .o_wready       (wready),
        .o_bresp        (bresp),
        .o_bvalid       (bvalid),
        .i_bready       (bready),
        .i_araddr       (araddr),
        .i_arvalid      (arvalid),
        .o_arready      (arready),
        .o_rdata        (rdata),
        .o_rresp        (rresp),
        .o_rvalid       (rvalid),
        .i_rready       (rready),
        .o_tx_hdr       (tx_hdr),
        .o_tx_hdr_valid (tx_valid),
        .i_tx_hdr_ready (tx_ready),
        .i_rx_hdr       (rx_hdr),
        .i_rx_hdr_valid (rx_valid),
        .o_rx_hdr_ready (rx_ready)
    );

    always #50 clk = ~clk;

    function automatic string test_name(input logic [31:0] id);
        case (id)
            1: return "register_access";
            2: return "active_open";
            3: return "handshake";
            4: return "retransmit";
            5: return "close";
            6: return "peer_reset";
            default: return "unknown";
        endcase
    endfunction

    // header columns: src dst seq ack flags window
    function automatic tcp_hdr_t hdr_from_step(input int base);
        tcp_hdr_t h;
        h.src_port = steps[base+2][15:0];
        h.dst_port = steps[base+3][15:0];
        h.seq      = steps[base+4];
        h.ack      = steps[base+5];
        h.flags    = steps[base+6][7:0];
        h.window   = steps[base+7][15:0];
        return h;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare(input string what, input logic [127:0] expected,
                           input logic [127:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERR %s expected %h actual %h", what, expected, actual));
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] resp, input string name);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        awaddr   = addr;
        wdata    = data;
        awvalid  = 1'b1;
        wvalid   = 1'b1;
        // ready seen before the edge updates the DUT
        while (!accepted) begin
            @(posedge clk);
            accepted = awready && wready;
            if (!accepted) begin
                waited++;
                if (waited > BUS_WAIT) begin
                    abort_run($sformatf("%s: DUT never accepted the write", name));
                end
            end
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // response one cycle after the handshake
        compare({name, " bvalid"}, 1'b1, bvalid);
        compare({name, " bresp"}, resp, bresp);
        @(negedge clk);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] data,
                            input logic [1:0] resp, input string name);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        araddr   = addr;
        arvalid  = 1'b1;
        while (!accepted) begin
            @(posedge clk);
            accepted = arready;
            if (!accepted) begin
                waited++;
                if (waited > BUS_WAIT) begin
                    abort_run($sformatf("%s: DUT never accepted the read", name));
                end
            end
        end
        @(negedge clk);
        arvalid = 1'b0;
        compare({name, " rvalid"}, 1'b1, rvalid);
        compare({name, " rresp"}, resp, rresp);
        compare({name, " rdata"}, data, rdata);
        @(negedge clk);
    endtask

    // ready is random, the header moves on the next rising edge
    task automatic expect_tx_hdr(input tcp_hdr_t expected, input string name);
        int   waited;
        logic take;
        waited = 0;
        take   = 1'b0;
        while (!take) begin
            tx_ready = ($urandom_range(3) != 0);
            take     = tx_valid && tx_ready;
            if (take) begin
                compare({name, " tx header"}, expected, tx_hdr);
            end else begin
                waited++;
                if (waited > TX_WAIT) begin
                    abort_run($sformatf("%s: expected tx header never appeared", name));
                end
                @(negedge clk);
            end
        end
        @(negedge clk);
        tx_ready = 1'b0;
    endtask

    task automatic inject_rx_hdr(input tcp_hdr_t hdr, input string name);
        int waited;
        waited   = 0;
        rx_hdr   = hdr;
        rx_valid = 1'b1;
        while (!rx_ready) begin
            waited++;
            if (waited > BUS_WAIT) begin
                abort_run($sformatf("%s: DUT never accepted the rx header", name));
            end
            @(negedge clk);
        end
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic idle_no_tx(input int cycles, input string name);
        tx_ready = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            compare({name, " tx valid"}, 1'b0, tx_valid);
        end
    endtask

    initial begin
        int          idx;
        int          base;
        logic        finished;
        logic [31:0] op;
        string       name;

        clk      = 1'b0;
        rst_n    = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wvalid   = 1'b0;
        bready   = 1'b1;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b1;
        tx_ready = 1'b0;
        rx_hdr   = '0;
        rx_valid = 1'b0;
        void'($urandom(SEED));

        $readmemh("tcp_stream_testdata.txt", steps);
        if ($isunknown(steps[0])) begin
            abort_run("test data file could not be read");
        end

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        idx      = 0;
        finished = 1'b0;
        while (!finished) begin
            base = idx * STEP_WORDS;
            op   = steps[base];
            name = $sformatf("%s step %0d", test_name(steps[base+1]), idx);
            case (op)
                OP_WRITE: write_reg(steps[base+2][7:0], steps[base+3], steps[base+4][1:0], name);
                OP_READ:  read_reg(steps[base+2][7:0], steps[base+3], steps[base+4][1:0], name);
                OP_TX:    expect_tx_hdr(hdr_from_step(base), name);
                OP_RX:    inject_rx_hdr(hdr_from_step(base), name);
                OP_IDLE:  idle_no_tx(int'(steps[base+2]), name);
                OP_END:   finished = 1'b1;
                default:  abort_run($sformatf("unknown step code at step %0d", idx));
            endcase
            idx++;
            if (!finished && idx == STEP_MAX) begin
                abort_run("test data has no end marker");
            end
        end

        if (uut.u_sva.fail_count != 0) begin
            abort_run("assertion failures were reported during the run");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- tcp_stream_testdata.txt
// op id f0..f5, op 1 write and 2 read use (addr data resp), op 5 idle uses (cycles)
// op 3 expect tx and 4 inject rx use (src dst seq ack flags window), op 0 ends
2 1 0C 00000000 0 0 0 0
1 1 04 56781234 0 0 0 0
1 1 08 A5000010 0 0 0 0
2 1 04 56781234 0 0 0 0
2 1 08 A5000010 0 0 0 0
2 1 10 00000000 2 0 0 0
1 1 10 FFFFFFFF 2 0 0 0
1 1 3C 00000007 2 0 0 0
2 1 04 56781234 0 0 0 0
2 1 08 A5000010 0 0 0 0
2 1 00 00000000 0 0 0 0
5 1 10 0 0 0 0 0
// active open
1 2 00 00000001 0 0 0 0
2 2 00 00000001 0 0 0 0
1 2 00 00000003 0 0 0 0
3 2 1234 5678 A5000010 00000000 02 1000
// handshake, wrong ports first
4 3 1111 1234 77000000 A5000011 12 2000
5 3 0C 0 0 0 0 0
2 3 0C 00000001 0 0 0 0
4 3 5678 1234 77000000 A5000011 12 2000
3 3 1234 5678 A5000011 77000001 10 1000
2 3 0C 00000002 0 0 0 0
// close
1 5 00 00000005 0 0 0 0
3 5 1234 5678 A5000011 77000001 11 1000
4 5 5678 1234 77000001 A5000012 10 2000
5 5 04 0 0 0 0 0
2 5 0C 00000000 0 0 0 0
// open with no reply
1 4 00 00000003 0 0 0 0
3 4 1234 5678 A5000010 00000000 02 1000
3 4 1234 5678 A5000010 00000000 02 1000
3 4 1234 5678 A5000010 00000000 02 1000
5 4 50 0 0 0 0 0
2 4 0C 00000104 0 0 0 0
// reset by the peer
1 6 00 00000003 0 0 0 0
3 6 1234 5678 A5000010 00000000 02 1000
2 6 0C 00000001 0 0 0 0
4 6 5678 1234 33000000 A5000011 12 2000
3 6 1234 5678 A5000011 33000001 10 1000
2 6 0C 00000002 0 0 0 0
4 6 5678 1234 33000001 00000000 04 2000
5 6 04 0 0 0 0 0
2 6 0C 00000104 0 0 0 0
1 6 00 00000003 0 0 0 0
3 6 1234 5678 A5000010 00000000 02 1000
2 6 0C 00000001 0 0 0 0
0 0 0 0 0 0 0 0

//--- tcp_stream.f
+incdir+.
tcp_pkg.sv
tcp_stream_regs.sv
tcp_state_manager.sv
tcp_retx_timer.sv
tcp_tx_ctrl.sv
tcp_rx_ctrl.sv
tcp_stream.sv
tcp_stream_sva.sv
tb_tcp_stream.sv

//--- Bender.yml
package:
  name: tcp_stream

sources:
  - include_dirs:
      - .
    files:
      - tcp_pkg.sv
      - tcp_stream_regs.sv
      - tcp_state_manager.sv
      - tcp_retx_timer.sv
      - tcp_tx_ctrl.sv
      - tcp_rx_ctrl.sv
      - tcp_stream.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tcp_stream_sva.sv
      - tb_tcp_stream.sv
